//--- src/rv_pkg.sv
package rv_pkg;

    // register index width
    localparam int REG_IDX_W = 5;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // operations understood by the ALU
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // funct3 values
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 values, alt selects sub and sra
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

//--- src/fetch_stage.sv
module fetch_stage #(
    parameter int XLEN       = 32,
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          imem_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_i,
    input  logic [XLEN-1:0]               imem_wdata_i,
    output logic                          fd_valid_o,
    output logic [XLEN-1:0]               fd_pc_o,
    output logic [31:0]                   fd_instr_o
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    logic [31:0]     imem [IMEM_DEPTH];
    logic [XLEN-1:0] pc;
    logic [XLEN-3:0] pc_word;
    logic [31:0]     fetch_word;

    // loading is only allowed while the core sits in reset
    always_ff @(posedge clk) begin
        if (!rst_n_i && imem_we_i) begin
            imem[imem_addr_i] <= imem_wdata_i[31:0];
        end
    end

    assign pc_word = pc[XLEN-1:2];

    // out of range fetches see a zero word, which decodes as a bubble
    assign fetch_word = (pc_word < IMEM_DEPTH) ? imem[pc[IMEM_AW+1:2]] : 32'h0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc         <= '0;
            fd_valid_o <= 1'b0;
        end else begin
            pc         <= pc + XLEN'(4);
            fd_valid_o <= 1'b1;
        end
    end

    // fetch/decode register payload
    always_ff @(posedge clk) begin
        fd_pc_o    <= pc;
        fd_instr_o <= fetch_word;
    end

endmodule

//--- src/reg_file.sv
module reg_file import rv_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [REG_IDX_W-1:0] rs1_idx_i,
    input  logic [REG_IDX_W-1:0] rs2_idx_i,
    output logic [XLEN-1:0]      rs1_val_o,
    output logic [XLEN-1:0]      rs2_val_o,
    input  logic                 wen_i,
    input  logic [REG_IDX_W-1:0] rd_idx_i,
    input  logic [XLEN-1:0]      rd_data_i
);

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && rd_idx_i != '0) begin
            regs[rd_idx_i] <= rd_data_i;
        end
    end

    // same-cycle write is passed straight through to the reader
    function automatic logic [XLEN-1:0] read_port(input logic [REG_IDX_W-1:0] idx);
        logic [XLEN-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (wen_i && rd_idx_i == idx) begin
            val = rd_data_i;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1_val_o = read_port(rs1_idx_i);
        rs2_val_o = read_port(rs2_idx_i);
    end

endmodule

//--- src/decode_stage.sv
module decode_stage import rv_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 fd_valid_i,
    input  logic [XLEN-1:0]      fd_pc_i,
    input  logic [31:0]          fd_instr_i,
    input  logic                 wb_wen_i,
    input  logic [REG_IDX_W-1:0] wb_rd_idx_i,
    input  logic [XLEN-1:0]      wb_data_i,
    output logic                 de_valid_o,
    output logic [XLEN-1:0]      de_pc_o,
    output logic [31:0]          de_instr_o,
    output logic [XLEN-1:0]      de_rs1_val_o,
    output logic [XLEN-1:0]      de_rs2_val_o,
    output logic [XLEN-1:0]      de_imm_o,
    output logic                 de_use_imm_o,
    output alu_op_e              de_alu_op_o,
    output logic [REG_IDX_W-1:0] de_rs1_idx_o,
    output logic [REG_IDX_W-1:0] de_rs2_idx_o,
    output logic [REG_IDX_W-1:0] de_rd_idx_o,
    output logic                 de_wen_o
);

    opcode_e              opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [REG_IDX_W-1:0] rd_idx;
    logic [XLEN-1:0]      rs1_val;
    logic [XLEN-1:0]      rs2_val;
    logic [XLEN-1:0]      imm;
    logic                 use_imm;
    logic                 supported;
    alu_op_e              alu_op;

    assign opcode  = opcode_e'(fd_instr_i[6:0]);
    assign funct3  = fd_instr_i[14:12];
    assign funct7  = fd_instr_i[31:25];
    assign rs1_idx = fd_instr_i[19:15];
    assign rs2_idx = fd_instr_i[24:20];
    assign rd_idx  = fd_instr_i[11:7];

    reg_file #(
        .XLEN      (XLEN)
    ) reg_file_u (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rs1_idx_i (rs1_idx),
        .rs2_idx_i (rs2_idx),
        .rs1_val_o (rs1_val),
        .rs2_val_o (rs2_val),
        .wen_i     (wb_wen_i),
        .rd_idx_i  (wb_rd_idx_i),
        .rd_data_i (wb_data_i)
    );

    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        supported = 1'b0;
        // I-type by default, lui overrides
        imm       = XLEN'($signed(fd_instr_i[31:20]));
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                use_imm   = (opcode == OPC_OP_IMM);
                supported = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op = (!use_imm && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     alu_op = ALU_SLL;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_SLTU:    alu_op = ALU_SLTU;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_SRL_SRA: alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:      alu_op = ALU_OR;
                    default:    alu_op = ALU_AND;
                endcase
                // funct7 must be legal wherever it is a real field
                if (!use_imm || funct3 == F3_SLL || funct3 == F3_SRL_SRA) begin
                    if (funct7 == F7_ALT) begin
                        supported = (funct3 == F3_SRL_SRA) ||
                                    (!use_imm && funct3 == F3_ADD_SUB);
                    end else if (funct7 != F7_BASE) begin
                        supported = 1'b0;
                    end
                end
            end
            OPC_LUI: begin
                alu_op    = ALU_PASS_B;
                use_imm   = 1'b1;
                supported = 1'b1;
                imm       = XLEN'($signed({fd_instr_i[31:12], 12'h000}));
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            de_valid_o <= 1'b0;
            de_wen_o   <= 1'b0;
        end else begin
            de_valid_o <= fd_valid_i;
            // bubbles and x0 destinations never write back
            de_wen_o   <= supported && rd_idx != '0;
        end
    end

    always_ff @(posedge clk) begin
        de_pc_o      <= fd_pc_i;
        de_instr_o   <= fd_instr_i;
        de_rs1_val_o <= rs1_val;
        de_rs2_val_o <= rs2_val;
        de_imm_o     <= imm;
        de_use_imm_o <= use_imm;
        de_alu_op_o  <= alu_op;
        de_rs1_idx_o <= rs1_idx;
        de_rs2_idx_o <= rs2_idx;
        de_rd_idx_o  <= rd_idx;
    end

endmodule

//--- src/execute_stage.sv
module execute_stage import rv_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 de_valid_i,
    input  logic [XLEN-1:0]      de_pc_i,
    input  logic [31:0]          de_instr_i,
    input  logic [XLEN-1:0]      de_rs1_val_i,
    input  logic [XLEN-1:0]      de_rs2_val_i,
    input  logic [XLEN-1:0]      de_imm_i,
    input  logic                 de_use_imm_i,
    input  alu_op_e              de_alu_op_i,
    input  logic [REG_IDX_W-1:0] de_rs1_idx_i,
    input  logic [REG_IDX_W-1:0] de_rs2_idx_i,
    input  logic [REG_IDX_W-1:0] de_rd_idx_i,
    input  logic                 de_wen_i,
    output logic                 ew_valid_o,
    output logic [XLEN-1:0]      ew_pc_o,
    output logic [31:0]          ew_instr_o,
    output logic [REG_IDX_W-1:0] ew_rd_idx_o,
    output logic                 ew_wen_o,
    output logic [XLEN-1:0]      ew_result_o
);

    logic            fwd_en;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_res;

    // result of the previous instruction is still sitting in ew
    assign fwd_en  = ew_valid_o && ew_wen_o && ew_rd_idx_o != '0;
    assign op_a    = (fwd_en && ew_rd_idx_o == de_rs1_idx_i) ? ew_result_o : de_rs1_val_i;
    assign rs2_fwd = (fwd_en && ew_rd_idx_o == de_rs2_idx_i) ? ew_result_o : de_rs2_val_i;
    assign op_b    = de_use_imm_i ? de_imm_i : rs2_fwd;
    assign shamt   = op_b[4:0];

    always_comb begin
        case (de_alu_op_i)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_res = XLEN'(op_a < op_b);
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ew_valid_o <= 1'b0;
            ew_wen_o   <= 1'b0;
        end else begin
            ew_valid_o <= de_valid_i;
            ew_wen_o   <= de_valid_i && de_wen_i;
        end
    end

    always_ff @(posedge clk) begin
        ew_pc_o     <= de_pc_i;
        ew_instr_o  <= de_instr_i;
        ew_rd_idx_o <= de_rd_idx_i;
        ew_result_o <= alu_res;
    end

endmodule

//--- src/rv_core_top.sv
module rv_core_top import rv_pkg::*; #(
    parameter int XLEN       = 32,
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          imem_we_i,
    input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr_i,
    input  logic [XLEN-1:0]               imem_wdata_i,
    output logic                          retire_valid_o,
    output logic [XLEN-1:0]               retire_pc_o,
    output logic [31:0]                   retire_instr_o,
    output logic                          retire_we_o,
    output logic [REG_IDX_W-1:0]          retire_rd_o,
    output logic [XLEN-1:0]               retire_data_o
);

    // fetch -> decode
    logic                 fd_valid;
    logic [XLEN-1:0]      fd_pc;
    logic [31:0]          fd_instr;

    // decode -> execute
    logic                 de_valid;
    logic [XLEN-1:0]      de_pc;
    logic [31:0]          de_instr;
    logic [XLEN-1:0]      de_rs1_val;
    logic [XLEN-1:0]      de_rs2_val;
    logic [XLEN-1:0]      de_imm;
    logic                 de_use_imm;
    alu_op_e              de_alu_op;
    logic [REG_IDX_W-1:0] de_rs1_idx;
    logic [REG_IDX_W-1:0] de_rs2_idx;
    logic [REG_IDX_W-1:0] de_rd_idx;
    logic                 de_wen;

    // execute -> writeback
    logic                 ew_valid;
    logic [XLEN-1:0]      ew_pc;
    logic [31:0]          ew_instr;
    logic [REG_IDX_W-1:0] ew_rd_idx;
    logic                 ew_wen;
    logic [XLEN-1:0]      ew_result;
    logic                 wb_wen;

    assign wb_wen = ew_valid && ew_wen;

    fetch_stage #(
        .XLEN         (XLEN),
        .IMEM_DEPTH   (IMEM_DEPTH)
    ) fetch_u (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .imem_we_i    (imem_we_i),
        .imem_addr_i  (imem_addr_i),
        .imem_wdata_i (imem_wdata_i),
        .fd_valid_o   (fd_valid),
        .fd_pc_o      (fd_pc),
        .fd_instr_o   (fd_instr)
    );

    decode_stage #(
        .XLEN         (XLEN)
    ) decode_u (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fd_valid_i   (fd_valid),
        .fd_pc_i      (fd_pc),
        .fd_instr_i   (fd_instr),
        .wb_wen_i     (wb_wen),
        .wb_rd_idx_i  (ew_rd_idx),
        .wb_data_i    (ew_result),
        .de_valid_o   (de_valid),
        .de_pc_o      (de_pc),
        .de_instr_o   (de_instr),
        .de_rs1_val_o (de_rs1_val),
        .de_rs2_val_o (de_rs2_val),
        .de_imm_o     (de_imm),
        .de_use_imm_o (de_use_imm),
        .de_alu_op_o  (de_alu_op),
        .de_rs1_idx_o (de_rs1_idx),
        .de_rs2_idx_o (de_rs2_idx),
        .de_rd_idx_o  (de_rd_idx),
        .de_wen_o     (de_wen)
    );

    execute_stage #(
        .XLEN         (XLEN)
    ) execute_u (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .de_valid_i   (de_valid),
        .de_pc_i      (de_pc),
        .de_instr_i   (de_instr),
        .de_rs1_val_i (de_rs1_val),
        .de_rs2_val_i (de_rs2_val),
        .de_imm_i     (de_imm),
        .de_use_imm_i (de_use_imm),
        .de_alu_op_i  (de_alu_op),
        .de_rs1_idx_i (de_rs1_idx),
        .de_rs2_idx_i (de_rs2_idx),
        .de_rd_idx_i  (de_rd_idx),
        .de_wen_i     (de_wen),
        .ew_valid_o   (ew_valid),
        .ew_pc_o      (ew_pc),
        .ew_instr_o   (ew_instr),
        .ew_rd_idx_o  (ew_rd_idx),
        .ew_wen_o     (ew_wen),
        .ew_result_o  (ew_result)
    );

    // every valid ew entry retires this cycle
    assign retire_valid_o = ew_valid;
    assign retire_pc_o    = ew_pc;
    assign retire_instr_o = ew_instr;
    assign retire_we_o    = wb_wen;
    assign retire_rd_o    = ew_rd_idx;
    assign retire_data_o  = ew_result;

endmodule

//--- verif/rv_core_assert.sv
module rv_core_assert import rv_pkg::*; #(
    parameter int XLEN = 32
) (
    input logic                 clk,
    input logic                 rst_n_i,
    input logic                 retire_valid_i,
    input logic [XLEN-1:0]      retire_pc_i,
    input logic                 retire_we_i,
    input logic [REG_IDX_W-1:0] retire_rd_i
);

    // failures so far, read by the testbench at the end of the run
    int fail_count = 0;

    // a reset cycle leaves the retire port idle
    a_idle_in_reset: assert property (@(posedge clk) !rst_n_i |=> !retire_valid_i)
        else begin
            $error("retire_valid_o high right after a reset cycle");
            fail_count++;
        end

    // no branches, so back-to-back retirements are sequential
    a_pc_step: assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_valid_i && $past(retire_valid_i) |-> retire_pc_i == $past(retire_pc_i) + XLEN'(4))
        else begin
            $error("retire_pc_o did not advance by 4");
            fail_count++;
        end

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_we_i |-> retire_rd_i != '0)
        else begin
            $error("retire_we_o high with destination x0");
            fail_count++;
        end

endmodule

bind rv_core_top rv_core_assert #(
    .XLEN           (XLEN)
) assert_u (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .retire_valid_i (retire_valid_o),
    .retire_pc_i    (retire_pc_o),
    .retire_we_i    (retire_we_o),
    .retire_rd_i    (retire_rd_o)
);

//--- verif/rv_core_tb.sv
module rv_core_tb import rv_pkg::*; ();

    localparam int XLEN              = 32;
    localparam int IMEM_DEPTH        = 64;
    localparam int IMEM_AW           = $clog2(IMEM_DEPTH);
    localparam int CLK_PERIOD        = 4;
    localparam int RST_CYCLES        = 4;
    // release edge fills fd, two more reach ew, seen on the next one
    localparam int FIRST_RETIRE_EDGE = 4;
    // program load, reset, pipeline fill, every retirement and some slack
    localparam int WATCHDOG_CYCLES   = 2 * IMEM_DEPTH + RST_CYCLES + 20;

    logic                 clk;
    logic                 rst_n;
    logic                 imem_we;
    logic [IMEM_AW-1:0]   imem_addr;
    logic [XLEN-1:0]      imem_wdata;
    logic                 retire_valid;
    logic [XLEN-1:0]      retire_pc;
    logic [31:0]          retire_instr;
    logic                 retire_we;
    logic [REG_IDX_W-1:0] retire_rd;
    logic [XLEN-1:0]      retire_data;

    logic [31:0] prog [IMEM_DEPTH];
    logic [31:0] model_regs [32];
    int          retired;
    int          edge_cnt;
    logic        exp_we;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;

    rv_core_top #(
        .XLEN           (XLEN),
        .IMEM_DEPTH     (IMEM_DEPTH)
    ) uut (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .imem_we_i      (imem_we),
        .imem_addr_i    (imem_addr),
        .imem_wdata_i   (imem_wdata),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_instr_o (retire_instr),
        .retire_we_o    (retire_we),
        .retire_rd_o    (retire_rd),
        .retire_data_o  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
        if (got !== exp) begin
            $display("[ERROR] %s exp=%h got=%h", name, exp, got);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // random instruction over x0..x7
    function automatic logic [31:0] gen_instr();
        int          sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] rnd;
        logic [31:0] word;
        sel = $urandom_range(15, 0);
        rd  = 5'($urandom_range(7, 0));
        rs1 = 5'($urandom_range(7, 0));
        rs2 = 5'($urandom_range(7, 0));
        f3  = 3'($urandom_range(7, 0));
        rnd = $urandom();
        // sub and sra get the alternate funct7 half of the time
        f7  = ((f3 == 3'd0 || f3 == 3'd5) && rnd[0]) ? 7'b0100000 : 7'b0000000;
        if (sel == 0) begin
            word = 32'h0;
        end else if (sel == 1) begin
            // M extension encoding, outside the subset
            word = {7'b0000001, rs2, rs1, f3, rd, OPC_OP};
        end else if (sel < 4) begin
            word = {rnd[31:12], rd, OPC_LUI};
        end else if (sel < 10) begin
            word = {f7, rs2, rs1, f3, rd, OPC_OP};
        end else if (f3 == 3'd1 || f3 == 3'd5) begin
            word = {((f3 == 3'd5) ? f7 : 7'b0000000), rnd[24:20], rs1, f3, rd, OPC_OP_IMM};
        end else begin
            word = {rnd[31:20], rs1, f3, rd, OPC_OP_IMM};
        end
        return word;
    endfunction

    // expected architectural effect of one instruction
    function automatic void ref_exec(input logic [31:0] instr, input logic [31:0] regs [32],
                                     output logic we, output logic [4:0] rd,
                                     output logic [31:0] val);
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic        is_op;
        logic        ok;
        a     = regs[instr[19:15]];
        f3    = instr[14:12];
        f7    = instr[31:25];
        rd    = instr[11:7];
        is_op = (instr[6:0] == OPC_OP);
        ok    = 1'b0;
        val   = 32'h0;
        if (instr[6:0] == OPC_LUI) begin
            ok  = 1'b1;
            val = {instr[31:12], 12'h000};
        end else if (is_op || instr[6:0] == OPC_OP_IMM) begin
            if (is_op) begin
                b  = regs[instr[24:20]];
                ok = (f7 == 7'b0000000) || (f7 == 7'b0100000 && (f3 == 3'd0 || f3 == 3'd5));
            end else begin
                b = {{20{instr[31]}}, instr[31:20]};
                if (f3 == 3'd1) begin
                    ok = (f7 == 7'b0000000);
                end else if (f3 == 3'd5) begin
                    ok = (f7 == 7'b0000000) || (f7 == 7'b0100000);
                end else begin
                    ok = 1'b1;
                end
            end
            case (f3)
                3'd0: val = (is_op && f7[5]) ? a - b : a + b;
                3'd1: val = a << b[4:0];
                3'd2: val = {31'b0, $signed(a) < $signed(b)};
                3'd3: val = {31'b0, a < b};
                3'd4: val = a ^ b;
                3'd5: begin
                    if (f7[5]) begin
                        val = $signed(a) >>> b[4:0];
                    end else begin
                        val = a >> b[4:0];
                    end
                end
                3'd6: val = a | b;
                default: val = a & b;
            endcase
        end
        we = ok && rd != 5'd0;
    endfunction

    initial begin
        rst_n      = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        retired    = 0;
        edge_cnt   = 0;
        void'($urandom(59));
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            prog[i] = gen_instr();
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        // program goes in while the core is held in reset
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= IMEM_AW'(i);
            imem_wdata <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        wait (retired == IMEM_DEPTH);
        // let the bound assertions see the last retirements
        repeat (2) @(posedge clk);
        if (uut.assert_u.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    always @(posedge clk) begin
        if (rst_n && retired < IMEM_DEPTH) begin
            edge_cnt = edge_cnt + 1;
            check_val("retire_valid_o", 32'(edge_cnt >= FIRST_RETIRE_EDGE), 32'(retire_valid));
            if (!retire_valid) begin
                check_val("retire_we_o", 32'h0, 32'(retire_we));
            end else begin
                ref_exec(prog[retired], model_regs, exp_we, exp_rd, exp_data);
                check_val("retire_pc_o", 32'(retired * 4), retire_pc);
                check_val("retire_instr_o", prog[retired], retire_instr);
                check_val("retire_we_o", 32'(exp_we), 32'(retire_we));
                check_val("retire_rd_o", 32'(exp_rd), 32'(retire_rd));
                if (exp_we) begin
                    check_val("retire_data_o", exp_data, retire_data);
                    model_regs[exp_rd] = exp_data;
                end
                retired = retired + 1;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired with %0d of %0d instructions retired", retired, IMEM_DEPTH);
        $display("ERRORS FOUND");
        $fatal(1);
    end

endmodule

//--- rv_core_top.f
src/rv_pkg.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/rv_core_top.sv
verif/rv_core_assert.sv
verif/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/fetch_stage.sv
  - src/reg_file.sv
  - src/decode_stage.sv
  - src/execute_stage.sv
  - src/rv_core_top.sv
  - target: test
    files:
      - verif/rv_core_assert.sv
      - verif/rv_core_tb.sv
